// File: logic/avl_dacfifo_pkg.sv
// Widths, FIFO depth and fill marks of the DAC read buffer
// Avalon read state encoding and the Gray decode helper

package avl_dacfifo_pkg;

  // ==================================================
  // Data path and FIFO geometry
  // ==================================================
  localparam int AVL_DATA_WIDTH = 128;
  localparam int DAC_DATA_WIDTH = 32;
  localparam int MEM_RATIO = AVL_DATA_WIDTH / DAC_DATA_WIDTH;
  localparam int MEM_LANE_WIDTH = $clog2(MEM_RATIO);

  // 256 samples on the DAC side, which is 64 words on the Avalon side
  localparam int DAC_MEM_ADDRESS_WIDTH = 8;
  localparam int AVL_MEM_ADDRESS_WIDTH = DAC_MEM_ADDRESS_WIDTH - MEM_LANE_WIDTH;
  localparam int AVL_MEM_DEPTH = 2 ** AVL_MEM_ADDRESS_WIDTH;

  // ==================================================
  // Avalon addressing and fill control
  // ==================================================
  localparam int AVL_ADDRESS_WIDTH = 25;
  localparam logic [AVL_ADDRESS_WIDTH-1:0] AVL_DDR_BASE_ADDRESS = '0;

  // Fill marks in words
  localparam int AVL_MEM_THRESHOLD_LO = 8;
  localparam int AVL_MEM_THRESHOLD_HI = 56;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    WAIT = 2'd2
  } avl_rd_state_t;

  // Narrower pointers are decoded zero extended to this width
  function automatic logic [DAC_MEM_ADDRESS_WIDTH-1:0] gray_to_bin(
    input logic [DAC_MEM_ADDRESS_WIDTH-1:0] g
  );
    logic [DAC_MEM_ADDRESS_WIDTH-1:0] b;
    b[DAC_MEM_ADDRESS_WIDTH-1] = g[DAC_MEM_ADDRESS_WIDTH-1];
    for (int i = DAC_MEM_ADDRESS_WIDTH - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

// File: logic/avl_fifo_wr_if.sv
// FIFO write port and fill handshake between the Avalon side blocks

`timescale 1ns/100ps

interface avl_fifo_wr_if import avl_dacfifo_pkg::*; ();

  logic                             wr_enable;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] wr_address;
  logic [AVL_DATA_WIDTH-1:0]        wr_data;
  logic                             request_data;
  logic                             xfer_start;

  // Read controller, produces the words and the restart pulse
  modport ctrl (
    output wr_enable,
    output wr_data,
    output xfer_start,
    input  request_data
  );

  // Fill tracker, owns the write pointer and the back-pressure flag
  modport fill (
    input  wr_enable,
    input  xfer_start,
    output wr_address,
    output request_data
  );

  modport mem (
    input wr_enable,
    input wr_address,
    input wr_data
  );

endinterface

// File: logic/ad_mem_asym.sv
// Dual-clock FIFO storage, wide write port and narrow registered read port

`timescale 1ns/100ps

module ad_mem_asym import avl_dacfifo_pkg::*; (
  avl_fifo_wr_if.mem                  wr,
  input  logic                        avl_clk,
  input  logic                        dac_clk,
  input  logic [DAC_MEM_ADDRESS_WIDTH-1:0] rd_address,
  output logic [DAC_DATA_WIDTH-1:0]   rd_data
);

  logic [AVL_DATA_WIDTH-1:0] mem [0:AVL_MEM_DEPTH-1];

  logic [AVL_MEM_ADDRESS_WIDTH-1:0] rd_word_address;
  logic [MEM_LANE_WIDTH-1:0]        rd_lane;
  logic [AVL_DATA_WIDTH-1:0]        rd_word;

  // Whole words are stored in the Avalon domain
  always_ff @(posedge avl_clk) begin
    if (wr.wr_enable) begin
      mem[wr.wr_address] <= wr.wr_data;
    end
  end

  // Upper address bits pick the word, the low bits pick the sample lane
  assign rd_word_address = rd_address[DAC_MEM_ADDRESS_WIDTH-1:MEM_LANE_WIDTH];
  assign rd_lane = rd_address[MEM_LANE_WIDTH-1:0];
  assign rd_word = mem[rd_word_address];

  always_ff @(posedge dac_clk) begin
    rd_data <= rd_word[rd_lane*DAC_DATA_WIDTH +: DAC_DATA_WIDTH];
  end

endmodule

// File: logic/avl_rd_ctrl.sv
// Avalon-MM single read sequencer with wrapping word address
// Captures returned words and hands them to the FIFO write port

`timescale 1ns/100ps

module avl_rd_ctrl import avl_dacfifo_pkg::*; (
  input  logic                         avl_clk,
  input  logic                         avl_reset,
  input  logic                         avl_xfer_req,
  input  logic [AVL_ADDRESS_WIDTH-1:0] avl_last_address,
  input  logic                         avl_ready,
  input  logic                         avl_readdatavalid,
  input  logic [AVL_DATA_WIDTH-1:0]    avl_data,
  output logic [AVL_ADDRESS_WIDTH-1:0] avl_address,
  output logic                         avl_read,
  avl_fifo_wr_if.ctrl                  wr
);

  avl_rd_state_t state;
  logic          avl_xfer_req_d;
  logic          read_start;
  logic          accept;

  assign read_start = avl_xfer_req & wr.request_data;
  assign accept = avl_readdatavalid & avl_ready & (state == WAIT);

  // The read strobe is exactly the single REQ cycle
  assign avl_read = (state == REQ);

  // ==================================================
  // Transfer start detection
  // ==================================================
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      avl_xfer_req_d <= 1'b0;
      wr.xfer_start <= 1'b0;
    end else begin
      avl_xfer_req_d <= avl_xfer_req;
      wr.xfer_start <= avl_xfer_req & ~avl_xfer_req_d;
    end
  end

  // ==================================================
  // Read state machine, one outstanding read at most
  // ==================================================
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (read_start) state <= REQ;
        REQ: state <= WAIT;
        WAIT: if (accept) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Word address walks the block and wraps after the last address
  always_ff @(posedge avl_clk) begin
    if (avl_reset || wr.xfer_start) begin
      avl_address <= AVL_DDR_BASE_ADDRESS;
    end else if (accept) begin
      if (avl_address >= avl_last_address) begin
        avl_address <= AVL_DDR_BASE_ADDRESS;
      end else begin
        avl_address <= avl_address + 1'b1;
      end
    end
  end

  // Words that return after the request has dropped are discarded
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      wr.wr_enable <= 1'b0;
    end else begin
      wr.wr_enable <= accept & avl_xfer_req;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (accept) begin
      wr.wr_data <= avl_data;
    end
  end

endmodule

// File: logic/avl_fifo_fill.sv
// Avalon-domain write pointer, read pointer synchronizer and fill hysteresis

`timescale 1ns/100ps

module avl_fifo_fill import avl_dacfifo_pkg::*; (
  input  logic                             avl_clk,
  input  logic                             avl_reset,
  input  logic                             avl_xfer_req,
  input  logic [DAC_MEM_ADDRESS_WIDTH-1:0] dac_rd_address_g,
  output logic [AVL_MEM_ADDRESS_WIDTH-1:0] avl_wr_address_g,
  avl_fifo_wr_if.fill                      wr
);

  logic [DAC_MEM_ADDRESS_WIDTH-1:0] rd_address_m1;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] rd_address_m2;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] rd_address;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] rd_word_address;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] fill;
  logic                             drained;

  // Partly consumed words still count as occupied
  assign rd_word_address = rd_address[DAC_MEM_ADDRESS_WIDTH-1:MEM_LANE_WIDTH];
  assign fill = wr.wr_address - rd_word_address;

  // Once the transfer has stopped and the DAC has read everything, the
  // pointer goes back to zero so that a later restart sees an empty FIFO
  assign drained = ~avl_xfer_req &
                   (rd_address == {wr.wr_address, {MEM_LANE_WIDTH{1'b0}}});

  always_ff @(posedge avl_clk) begin
    if (avl_reset || wr.xfer_start || drained) begin
      wr.wr_address <= '0;
    end else if (wr.wr_enable) begin
      wr.wr_address <= wr.wr_address + 1'b1;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      avl_wr_address_g <= '0;
    end else begin
      avl_wr_address_g <= wr.wr_address ^ (wr.wr_address >> 1);
    end
  end

  // ==================================================
  // DAC read pointer, two flops then Gray decode
  // ==================================================
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      rd_address_m1 <= '0;
      rd_address_m2 <= '0;
      rd_address <= '0;
    end else begin
      rd_address_m1 <= dac_rd_address_g;
      rd_address_m2 <= rd_address_m1;
      rd_address <= gray_to_bin(rd_address_m2);
    end
  end

  // Stop reading near full, resume once the level has dropped low
  always_ff @(posedge avl_clk) begin
    if (avl_reset || !avl_xfer_req) begin
      wr.request_data <= 1'b0;
    end else if (fill >= AVL_MEM_THRESHOLD_HI) begin
      wr.request_data <= 1'b0;
    end else if (fill <= AVL_MEM_THRESHOLD_LO) begin
      wr.request_data <= 1'b1;
    end
  end

endmodule

// File: logic/dac_fifo_rd.sv
// DAC-domain read pointer, write pointer and request synchronizers
// Transfer request, underflow flag and sample output register

`timescale 1ns/100ps

module dac_fifo_rd import avl_dacfifo_pkg::*; (
  input  logic                             dac_clk,
  input  logic                             dac_reset,
  input  logic                             dac_valid,
  input  logic                             avl_xfer_req,
  input  logic [AVL_MEM_ADDRESS_WIDTH-1:0] avl_wr_address_g,
  input  logic [DAC_DATA_WIDTH-1:0]        rd_data,
  output logic [DAC_MEM_ADDRESS_WIDTH-1:0] rd_address,
  output logic [DAC_MEM_ADDRESS_WIDTH-1:0] dac_rd_address_g,
  output logic [DAC_DATA_WIDTH-1:0]        dac_data,
  output logic                             dac_xfer_req,
  output logic                             dac_dunf
);

  logic [AVL_MEM_ADDRESS_WIDTH-1:0] wr_address_m1;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] wr_address_m2;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] wr_address;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] wr_address_s;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] fill;
  logic                             xfer_req_m1;
  logic                             dac_avl_xfer_req;
  logic                             empty;
  logic                             rd_strobe;
  logic                             rd_strobe_d;
  logic                             dunf_d;

  // ==================================================
  // Clock domain crossing
  // ==================================================
  assign wr_address_s = gray_to_bin({{MEM_LANE_WIDTH{1'b0}}, wr_address_m2});

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      wr_address_m1 <= '0;
      wr_address_m2 <= '0;
      wr_address <= '0;
      xfer_req_m1 <= 1'b0;
      dac_avl_xfer_req <= 1'b0;
    end else begin
      wr_address_m1 <= avl_wr_address_g;
      wr_address_m2 <= wr_address_m1;
      wr_address <= wr_address_s[AVL_MEM_ADDRESS_WIDTH-1:0];
      xfer_req_m1 <= avl_xfer_req;
      dac_avl_xfer_req <= xfer_req_m1;
    end
  end

  // Fill in samples, the write side only ever adds whole words
  assign fill = {wr_address, {MEM_LANE_WIDTH{1'b0}}} - rd_address;
  assign empty = (fill == '0);
  assign rd_strobe = dac_xfer_req & dac_valid;

  // The pointer holds on an empty FIFO so the stream resumes without a gap
  always_ff @(posedge dac_clk) begin
    if (dac_reset || (!dac_avl_xfer_req && !dac_xfer_req)) begin
      rd_address <= '0;
    end else if (rd_strobe && !empty) begin
      rd_address <= rd_address + 1'b1;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_rd_address_g <= '0;
    end else begin
      dac_rd_address_g <= rd_address ^ (rd_address >> 1);
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_xfer_req <= 1'b0;
    end else if (dac_avl_xfer_req && !empty) begin
      dac_xfer_req <= 1'b1;
    end else if (!dac_avl_xfer_req && empty) begin
      dac_xfer_req <= 1'b0;
    end
  end

  // ==================================================
  // Output stage, one cycle behind the memory read
  // ==================================================
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      rd_strobe_d <= 1'b0;
      dunf_d <= 1'b0;
      dac_data <= '0;
      dac_dunf <= 1'b0;
    end else begin
      rd_strobe_d <= rd_strobe;
      dunf_d <= rd_strobe & empty;
      if (rd_strobe_d) begin
        dac_data <= dunf_d ? '0 : rd_data;
        dac_dunf <= dunf_d;
      end
    end
  end

endmodule

// File: logic/avl_dacfifo_rd.sv
// Top level of the DDR to DAC read buffer
// Avalon read side, asymmetric FIFO storage and DAC read side

`timescale 1ns/100ps

module avl_dacfifo_rd import avl_dacfifo_pkg::*; (
  input  logic                         avl_clk,
  input  logic                         avl_reset,
  input  logic                         dac_clk,
  input  logic                         dac_reset,
  input  logic                         avl_xfer_req,
  input  logic [AVL_ADDRESS_WIDTH-1:0] avl_last_address,
  input  logic                         avl_ready,
  input  logic                         avl_readdatavalid,
  input  logic [AVL_DATA_WIDTH-1:0]    avl_data,
  input  logic                         dac_valid,
  output logic [AVL_ADDRESS_WIDTH-1:0] avl_address,
  output logic                         avl_read,
  output logic [DAC_DATA_WIDTH-1:0]    dac_data,
  output logic                         dac_xfer_req,
  output logic                         dac_dunf
);

  logic [AVL_MEM_ADDRESS_WIDTH-1:0] avl_wr_address_g;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] dac_rd_address_g;
  logic [DAC_MEM_ADDRESS_WIDTH-1:0] mem_rd_address;
  logic [DAC_DATA_WIDTH-1:0]        mem_rd_data;

  avl_fifo_wr_if fifo_wr ();

  ad_mem_asym i_mem (
    .wr         (fifo_wr.mem),
    .avl_clk    (avl_clk),
    .dac_clk    (dac_clk),
    .rd_address (mem_rd_address),
    .rd_data    (mem_rd_data)
  );

  // ==================================================
  // Avalon clock domain
  // ==================================================
  avl_rd_ctrl i_rd_ctrl (
    .avl_clk           (avl_clk),
    .avl_reset         (avl_reset),
    .avl_xfer_req      (avl_xfer_req),
    .avl_last_address  (avl_last_address),
    .avl_ready         (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data          (avl_data),
    .avl_address       (avl_address),
    .avl_read          (avl_read),
    .wr                (fifo_wr.ctrl)
  );

  avl_fifo_fill i_fifo_fill (
    .avl_clk          (avl_clk),
    .avl_reset        (avl_reset),
    .avl_xfer_req     (avl_xfer_req),
    .dac_rd_address_g (dac_rd_address_g),
    .avl_wr_address_g (avl_wr_address_g),
    .wr               (fifo_wr.fill)
  );

  // ==================================================
  // DAC clock domain
  // ==================================================
  dac_fifo_rd i_dac_rd (
    .dac_clk          (dac_clk),
    .dac_reset        (dac_reset),
    .dac_valid        (dac_valid),
    .avl_xfer_req     (avl_xfer_req),
    .avl_wr_address_g (avl_wr_address_g),
    .rd_data          (mem_rd_data),
    .rd_address       (mem_rd_address),
    .dac_rd_address_g (dac_rd_address_g),
    .dac_data         (dac_data),
    .dac_xfer_req     (dac_xfer_req),
    .dac_dunf         (dac_dunf)
  );

endmodule

// File: tb/avl_ddr_model.sv
// Avalon-MM read slave standing in for the DDR block of DAC samples
// Answers single reads after a random latency with an address based pattern

`timescale 1ns/100ps

module avl_ddr_model import avl_dacfifo_pkg::*; #(
  parameter logic [DAC_DATA_WIDTH-1:0] DATA_OFFSET = '0
) (
  input  logic                         avl_clk,
  input  logic                         avl_read,
  input  logic [AVL_ADDRESS_WIDTH-1:0] avl_address,
  input  int                           lat_min,
  input  int                           lat_max,
  output logic                         avl_ready,
  output logic                         avl_readdatavalid,
  output logic [AVL_DATA_WIDTH-1:0]    avl_data
);

  integer seed;

  // Sample k of word a holds a*4+k plus the offset, lane 0 in the low bits
  initial begin
    int                           latency;
    logic [AVL_ADDRESS_WIDTH-1:0] address;
    seed = 32'h5562;
    avl_ready = 1'b1;
    avl_readdatavalid = 1'b0;
    avl_data = '0;
    forever begin
      @(posedge avl_clk);
      #2;
      if (avl_read === 1'b1) begin
        address = avl_address;
        latency = lat_min + ($unsigned($random(seed)) % (lat_max - lat_min + 1));
        repeat (latency) @(posedge avl_clk);
        #2;
        for (int k = 0; k < MEM_RATIO; k++) begin
          avl_data[k*DAC_DATA_WIDTH +: DAC_DATA_WIDTH] =
            address * MEM_RATIO + k + DATA_OFFSET;
        end
        avl_readdatavalid = 1'b1;
        @(posedge avl_clk);
        #2;
        avl_readdatavalid = 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_avl_dacfifo_rd.sv
// Testbench for the DDR to DAC read buffer with an Avalon read slave model
// Table driven transfers, sample order checker, fill bound and watchdog

`timescale 1ns/100ps

module tb_avl_dacfifo_rd import avl_dacfifo_pkg::*; ();

  localparam int NUM_ROWS = 4;
  localparam int AVL_PERIOD = 20;
  localparam int DAC_PERIOD = 32;
  localparam logic [DAC_DATA_WIDTH-1:0] SAMPLE_OFFSET = 32'h00a5_0000;
  // Samples the FIFO can still hold when a transfer is stopped
  localparam int DRAIN_SAMPLES = AVL_MEM_DEPTH * MEM_RATIO;

  typedef struct packed {
    int last_address;
    int lat_min;
    int lat_max;
    int duty;
    int samples;
    bit expect_dunf;
  } row_t;

  // Last address, latency range, dac_valid period, samples to check, underflow expected
  row_t rows [NUM_ROWS] = '{
    '{3,   1,  3,  1, 160, 1'b0},
    '{20,  1,  6,  4, 300, 1'b0},
    '{100, 1,  2,  3, 480, 1'b0},
    '{20,  12, 20, 1, 120, 1'b1}
  };

  logic                         avl_clk = 1'b0;
  logic                         dac_clk = 1'b0;
  logic                         avl_reset = 1'b1;
  logic                         dac_reset = 1'b1;
  logic                         avl_xfer_req = 1'b0;
  logic [AVL_ADDRESS_WIDTH-1:0] avl_last_address = '0;
  logic                         dac_valid = 1'b0;
  logic                         avl_ready;
  logic                         avl_readdatavalid;
  logic [AVL_DATA_WIDTH-1:0]    avl_data;
  logic [AVL_ADDRESS_WIDTH-1:0] avl_address;
  logic                         avl_read;
  logic [DAC_DATA_WIDTH-1:0]    dac_data;
  logic                         dac_xfer_req;
  logic                         dac_dunf;

  int lat_min = 1;
  int lat_max = 1;
  int duty = 1;
  int cur_row = 0;
  int errors = 0;
  int checks = 0;
  int sample_index = 0;
  int row_samples = 0;
  int row_dunf = 0;
  int row_reads = 0;
  bit first_read = 1'b0;

  initial begin
    forever #(AVL_PERIOD / 2) avl_clk = ~avl_clk;
  end

  initial begin
    forever #(DAC_PERIOD / 2) dac_clk = ~dac_clk;
  end

  avl_dacfifo_rd DUT (
    .avl_clk           (avl_clk),
    .avl_reset         (avl_reset),
    .dac_clk           (dac_clk),
    .dac_reset         (dac_reset),
    .avl_xfer_req      (avl_xfer_req),
    .avl_last_address  (avl_last_address),
    .avl_ready         (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data          (avl_data),
    .dac_valid         (dac_valid),
    .avl_address       (avl_address),
    .avl_read          (avl_read),
    .dac_data          (dac_data),
    .dac_xfer_req      (dac_xfer_req),
    .dac_dunf          (dac_dunf)
  );

  avl_ddr_model #(.DATA_OFFSET(SAMPLE_OFFSET)) ddr_model (
    .avl_clk           (avl_clk),
    .avl_read          (avl_read),
    .avl_address       (avl_address),
    .lat_min           (lat_min),
    .lat_max           (lat_max),
    .avl_ready         (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data          (avl_data)
  );

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("error at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  // The block repeats every (last address + 1) words of four samples
  function automatic logic [DAC_DATA_WIDTH-1:0] expected_sample(int index, int last_address);
    int block_samples;
    block_samples = (last_address + 1) * MEM_RATIO;
    return SAMPLE_OFFSET + (index % block_samples);
  endfunction

  // ==================================================
  // DAC strobes and sample checker
  // ==================================================
  initial begin
    int phase;
    phase = 0;
    forever begin
      @(posedge dac_clk);
      #2;
      dac_valid = (phase == 0);
      phase = (phase + 1 >= duty) ? 0 : phase + 1;
    end
  end

  // A strobe taken at one edge shows on dac_data after the next edge
  initial begin
    bit pending;
    bit xfer_before;
    pending = 1'b0;
    xfer_before = 1'b0;
    forever begin
      @(posedge dac_clk);
      #1;
      if (pending) begin
        if (dac_dunf) begin
          row_dunf++;
          check_value(dac_data, 0, "underflow sample is not zero");
        end else begin
          check_value(dac_data, expected_sample(sample_index, rows[cur_row].last_address),
                      "sample out of sequence");
          sample_index++;
          row_samples++;
        end
      end
      pending = dac_valid && xfer_before;
      xfer_before = dac_xfer_req;
    end
  end

  // Avalon reads, base address after a restart and the bound on buffered words
  initial begin
    forever begin
      @(posedge avl_clk);
      #1;
      if (avl_read === 1'b1) begin
        if (first_read) begin
          check_value(avl_address, 0, "first read after the start is not at the base");
          first_read = 1'b0;
        end
        row_reads++;
        check_value(row_reads - row_samples / MEM_RATIO > AVL_MEM_DEPTH, 0,
                    "reads ahead of the DAC exceed the FIFO depth");
      end
    end
  end

  // ==================================================
  // Stimulus table loop
  // ==================================================
  initial begin
    $timeformat(-9, 1, " ns", 0);
    fork
      begin
        repeat (16) @(posedge avl_clk);
        #2;
        avl_reset = 1'b0;
      end
      begin
        repeat (16) @(posedge dac_clk);
        #2;
        dac_reset = 1'b0;
      end
    join
    repeat (2) @(posedge avl_clk);
    #1;
    check_value(avl_read, 0, "avl_read after reset");
    check_value(avl_address, 0, "avl_address after reset");
    check_value(dac_xfer_req, 0, "dac_xfer_req after reset");
    check_value(dac_dunf, 0, "dac_dunf after reset");
    check_value(dac_data, 0, "dac_data after reset");

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_row = r;
      avl_last_address = rows[r].last_address[AVL_ADDRESS_WIDTH-1:0];
      lat_min = rows[r].lat_min;
      lat_max = rows[r].lat_max;
      duty = rows[r].duty;
      sample_index = 0;
      row_samples = 0;
      row_dunf = 0;
      row_reads = 0;
      first_read = 1'b1;
      check_value(dac_xfer_req, 0, "dac_xfer_req high before the transfer starts");
      @(posedge avl_clk);
      #2;
      avl_xfer_req = 1'b1;
      while (dac_xfer_req !== 1'b1) begin
        @(posedge dac_clk);
        #3;
      end
      while (row_samples < rows[r].samples) begin
        @(posedge dac_clk);
        #3;
      end
      // Stop the transfer and let the DAC drain what is still buffered
      @(posedge avl_clk);
      #2;
      avl_xfer_req = 1'b0;
      while (dac_xfer_req !== 1'b0) begin
        @(posedge dac_clk);
        #3;
      end
      repeat (32) @(posedge dac_clk);
      #3;
      if (rows[r].expect_dunf) begin
        check_value(row_dunf > 0, 1, "no underflow seen in the long latency row");
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Each row gets 40 DAC periods per strobe slot, drain included
  initial begin
    longint limit;
    limit = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += longint'(rows[r].samples + DRAIN_SAMPLES) * rows[r].duty * 40 * DAC_PERIOD;
    end
    limit += 100_000;
    #(limit);
    $display("Watchdog expired at %0t, the transfers did not complete", $time);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: all.f
logic/avl_dacfifo_pkg.sv
logic/avl_fifo_wr_if.sv
logic/ad_mem_asym.sv
logic/avl_rd_ctrl.sv
logic/avl_fifo_fill.sv
logic/dac_fifo_rd.sv
logic/avl_dacfifo_rd.sv
tb/avl_ddr_model.sv
tb/tb_avl_dacfifo_rd.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP      = tb_avl_dacfifo_rd
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS     = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
